// ==== rtl/memPkg.sv ====
// memPkg: shared sizes, address split and cache line state for the memory subsystem
package memPkg;

  //////////////////////////////////////////////////
  // word and address sizes
  //////////////////////////////////////////////////

  // data word carried on every port
  localparam int DATA_W = 32;

  // word address, RAM holds 2**ADDR_W words
  localparam int ADDR_W = 8;
  localparam int RAM_WORDS = 1 << ADDR_W;

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  // index bits, one word per line
  localparam int LINE_W = 3;
  localparam int NUM_LINES = 1 << LINE_W;

  // upper address bits kept with each line
  localparam int TAG_W = ADDR_W - LINE_W;

  //////////////////////////////////////////////////
  // RAM timing
  //////////////////////////////////////////////////

  // cycles from a sampled request to ack
  localparam int RAM_LAT = 2;
  // counter width for the latency count
  localparam int LAT_W = $clog2(RAM_LAT) + 1;

  // per-line state kept by the cache
  typedef enum logic [1:0] {
    invalid = 2'b00,
    clean   = 2'b01,
    dirty   = 2'b10
  } lineState_t;

endpackage

// ==== rtl/mainRam.sv ====
// mainRam: shared word RAM serving one four-phase request at a time after a fixed latency
module mainRam import memPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              ramReq,
  input  logic              ramWrite,
  input  logic [ADDR_W-1:0] ramAddr,
  input  logic [DATA_W-1:0] ramWData,
  output logic              ramAck,
  output logic [DATA_W-1:0] ramRData
);

  // word storage
  logic [DATA_W-1:0] mem [RAM_WORDS];

  // request accepted and counting down
  logic             busy;
  logic [LAT_W-1:0] latCnt;
  logic             doAccess;

  // last counted cycle, the access happens here
  assign doAccess = busy && (latCnt == LAT_W'(RAM_LAT - 1));

  //////////////////////////////////////////////////
  // handshake and latency control
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      latCnt <= '0;
      ramAck <= 1'b0;
    end else if (ramAck) begin
      // phase 4, drop ack once req is gone
      if (!ramReq) begin
        ramAck <= 1'b0;
      end
    end else if (doAccess) begin
      busy   <= 1'b0;
      ramAck <= 1'b1;
    end else if (busy) begin
      latCnt <= latCnt + 1'b1;
    end else if (ramReq) begin
      // new request sampled with ack low
      busy   <= 1'b1;
      latCnt <= '0;
    end
  end

  // array access, read data held while ack is high
  always_ff @(posedge clk) begin
    if (doAccess) begin
      if (ramWrite) begin
        mem[ramAddr] <= ramWData;
      end else begin
        ramRData <= mem[ramAddr];
      end
    end
  end

endmodule

// ==== rtl/busArbiter.sv ====
// busArbiter: round-robin sharing of the main RAM between the cache and the loader port
module busArbiter import memPkg::*; (
  input  logic              clk,
  input  logic              rst,
  // cache side
  input  logic              cReq,
  input  logic              cWrite,
  input  logic [ADDR_W-1:0] cAddr,
  input  logic [DATA_W-1:0] cWData,
  output logic              cAck,
  output logic [DATA_W-1:0] cRData,
  // loader side
  input  logic              ldReq,
  input  logic              ldWrite,
  input  logic [ADDR_W-1:0] ldAddr,
  input  logic [DATA_W-1:0] ldWData,
  output logic              ldAck,
  output logic [DATA_W-1:0] ldRData,
  // RAM side
  input  logic              ramAck,
  input  logic [DATA_W-1:0] ramRData,
  output logic              ramReq,
  output logic              ramWrite,
  output logic [ADDR_W-1:0] ramAddr,
  output logic [DATA_W-1:0] ramWData
);

  // grant state, owner 1 means loader
  logic granted;
  logic owner;
  // who got the previous grant, for fairness
  logic lastLd;
  logic ownerReq;

  assign ownerReq = owner ? ldReq : cReq;

  //////////////////////////////////////////////////
  // grant selection and release
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      granted <= 1'b0;
      owner   <= 1'b0;
      lastLd  <= 1'b0;
    end else if (!granted) begin
      // RAM idle, pick a requester
      if (!ramAck && (cReq || ldReq)) begin
        granted <= 1'b1;
        if (cReq && ldReq) begin
          // both waiting, the one not served last wins
          owner  <= !lastLd;
          lastLd <= !lastLd;
        end else begin
          owner  <= ldReq;
          lastLd <= ldReq;
        end
      end
    end else if (!ownerReq && !ramAck) begin
      // four-phase cycle of the owner is complete
      granted <= 1'b0;
    end
  end

  // forward the owner's request
  assign ramReq   = granted && ownerReq;
  assign ramWrite = owner ? ldWrite : cWrite;
  assign ramAddr  = owner ? ldAddr  : cAddr;
  assign ramWData = owner ? ldWData : cWData;

  // ack and data go back to the owner only
  assign cAck    = granted && !owner && ramAck;
  assign ldAck   = granted && owner && ramAck;
  assign cRData  = (granted && !owner) ? ramRData : '0;
  assign ldRData = (granted && owner) ? ramRData : '0;

endmodule

// ==== rtl/dataCache.sv ====
// dataCache: direct-mapped write-back cache for the host port with refill, writeback and flush visits
module dataCache import memPkg::*; (
  input  logic              clk,
  input  logic              rst,
  // host port
  input  logic              hostReq,
  input  logic              hostWrite,
  input  logic [ADDR_W-1:0] hostAddr,
  input  logic [DATA_W-1:0] hostWData,
  output logic              hostAck,
  output logic [DATA_W-1:0] hostRData,
  // flush visits
  input  logic [LINE_W-1:0] fIdx,
  input  logic              fReq,
  output logic              fAck,
  // toward the arbiter
  output logic              cReq,
  output logic              cWrite,
  output logic [ADDR_W-1:0] cAddr,
  output logic [DATA_W-1:0] cWData,
  input  logic              cAck,
  input  logic [DATA_W-1:0] cRData
);

  typedef enum logic [2:0] {
    csIdle,
    csWbReq,
    csWbRel,
    csMiss,
    csFillReq,
    csFillRel,
    csHostAck,
    csFlushAck
  } cacheState_t;

  // line storage
  logic [TAG_W-1:0]  tagArr [NUM_LINES];
  logic [DATA_W-1:0] dataArr [NUM_LINES];
  lineState_t        stateArr [NUM_LINES];

  cacheState_t       state;
  // current writeback belongs to a flush visit
  logic              fromFlush;
  // set from the first flush visit until the last line is done
  logic              flushBusy;

  // host address split
  logic [LINE_W-1:0] hIdx;
  logic [TAG_W-1:0]  hTag;
  logic              hit;

  assign hIdx = hostAddr[LINE_W-1:0];
  assign hTag = hostAddr[ADDR_W-1:LINE_W];
  assign hit  = (stateArr[hIdx] != invalid) && (tagArr[hIdx] == hTag);

  // handshake outputs decoded from state
  assign hostAck = (state == csHostAck);
  assign fAck    = (state == csFlushAck);
  assign cReq    = (state == csWbReq) || (state == csFillReq);

  //////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= csIdle;
      fromFlush <= 1'b0;
      flushBusy <= 1'b0;
      for (int i = 0; i < NUM_LINES; i++) begin
        stateArr[i] <= invalid;
      end
    end else begin
      case (state)
        csIdle: begin
          if (fReq) begin
            // flush visit, write back only a dirty line
            flushBusy <= 1'b1;
            fromFlush <= 1'b1;
            if (stateArr[fIdx] == dirty) begin
              cWrite <= 1'b1;
              cAddr  <= {tagArr[fIdx], fIdx};
              cWData <= dataArr[fIdx];
              state  <= csWbReq;
            end else begin
              state <= csFlushAck;
            end
          end else if (hostReq && !flushBusy) begin
            fromFlush <= 1'b0;
            if (hit) begin
              if (hostWrite) begin
                dataArr[hIdx]  <= hostWData;
                stateArr[hIdx] <= dirty;
              end else begin
                hostRData <= dataArr[hIdx];
              end
              state <= csHostAck;
            end else if (stateArr[hIdx] == dirty) begin
              // victim goes back to RAM first
              cWrite <= 1'b1;
              cAddr  <= {tagArr[hIdx], hIdx};
              cWData <= dataArr[hIdx];
              state  <= csWbReq;
            end else begin
              state <= csMiss;
            end
          end
        end
        csWbReq: begin
          if (cAck) begin
            // line now matches RAM
            if (fromFlush) begin
              stateArr[cAddr[LINE_W-1:0]] <= clean;
            end
            state <= csWbRel;
          end
        end
        csWbRel: begin
          if (!cAck) begin
            state <= fromFlush ? csFlushAck : csMiss;
          end
        end
        csMiss: begin
          if (hostWrite) begin
            // write allocate, a one-word line needs no refill
            tagArr[hIdx]   <= hTag;
            dataArr[hIdx]  <= hostWData;
            stateArr[hIdx] <= dirty;
            state          <= csHostAck;
          end else begin
            cWrite <= 1'b0;
            cAddr  <= hostAddr;
            state  <= csFillReq;
          end
        end
        csFillReq: begin
          if (cAck) begin
            tagArr[hIdx]   <= hTag;
            dataArr[hIdx]  <= cRData;
            stateArr[hIdx] <= clean;
            hostRData      <= cRData;
            state          <= csFillRel;
          end
        end
        csFillRel: begin
          if (!cAck) begin
            state <= csHostAck;
          end
        end
        csHostAck: begin
          // phase 4 toward the host
          if (!hostReq) begin
            state <= csIdle;
          end
        end
        csFlushAck: begin
          if (!fReq) begin
            // last line visited, hosts may run again
            if (fIdx == LINE_W'(NUM_LINES - 1)) begin
              flushBusy <= 1'b0;
            end
            state <= csIdle;
          end
        end
        default: begin
          state <= csIdle;
        end
      endcase
    end
  end

endmodule

// ==== rtl/cacheFlush.sv ====
// cacheFlush: flush sequencer visiting every cache line so dirty data reaches main RAM
module cacheFlush import memPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              flushReq,
  output logic              flushAck,
  output logic [LINE_W-1:0] fIdx,
  output logic              fReq,
  input  logic              fAck
);

  typedef enum logic [1:0] {
    fsIdle,
    fsReq,
    fsRel,
    fsDone
  } flushState_t;

  flushState_t state;

  // handshakes decoded from state
  assign fReq     = (state == fsReq);
  assign flushAck = (state == fsDone);

  //////////////////////////////////////////////////
  // line walk
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fsIdle;
      fIdx  <= '0;
    end else begin
      case (state)
        fsIdle: begin
          if (flushReq) begin
            fIdx  <= '0;
            state <= fsReq;
          end
        end
        // wait for the cache to finish this line
        fsReq: begin
          if (fAck) begin
            state <= fsRel;
          end
        end
        fsRel: begin
          if (!fAck) begin
            if (fIdx == LINE_W'(NUM_LINES - 1)) begin
              state <= fsDone;
            end else begin
              fIdx  <= fIdx + 1'b1;
              state <= fsReq;
            end
          end
        end
        fsDone: begin
          // hold flushAck until the requester lets go
          if (!flushReq) begin
            state <= fsIdle;
          end
        end
        default: begin
          state <= fsIdle;
        end
      endcase
    end
  end

endmodule

// ==== rtl/memSubsys.sv ====
// memSubsys: memory subsystem top joining cache, flush engine, arbiter and main RAM
module memSubsys import memPkg::*; (
  input  logic              clk,
  input  logic              rst,
  // host port
  input  logic              hostReq,
  input  logic              hostWrite,
  input  logic [ADDR_W-1:0] hostAddr,
  input  logic [DATA_W-1:0] hostWData,
  output logic              hostAck,
  output logic [DATA_W-1:0] hostRData,
  // loader port
  input  logic              ldReq,
  input  logic              ldWrite,
  input  logic [ADDR_W-1:0] ldAddr,
  input  logic [DATA_W-1:0] ldWData,
  output logic              ldAck,
  output logic [DATA_W-1:0] ldRData,
  // flush port
  input  logic              flushReq,
  output logic              flushAck
);

  // cache to arbiter
  logic              cReq;
  logic              cWrite;
  logic [ADDR_W-1:0] cAddr;
  logic [DATA_W-1:0] cWData;
  logic              cAck;
  logic [DATA_W-1:0] cRData;

  // arbiter to RAM
  logic              ramReq;
  logic              ramWrite;
  logic [ADDR_W-1:0] ramAddr;
  logic [DATA_W-1:0] ramWData;
  logic              ramAck;
  logic [DATA_W-1:0] ramRData;

  // flush engine to cache
  logic [LINE_W-1:0] fIdx;
  logic              fReq;
  logic              fAck;

  dataCache i_dataCache (.clk, .rst, .hostReq, .hostWrite, .hostAddr, .hostWData,
                         .hostAck, .hostRData, .fIdx, .fReq, .fAck,
                         .cReq, .cWrite, .cAddr, .cWData, .cAck, .cRData);

  cacheFlush i_cacheFlush (.clk, .rst, .flushReq, .flushAck, .fIdx, .fReq, .fAck);

  busArbiter i_busArbiter (.clk, .rst, .cReq, .cWrite, .cAddr, .cWData, .cAck, .cRData,
                           .ldReq, .ldWrite, .ldAddr, .ldWData, .ldAck, .ldRData,
                           .ramAck, .ramRData, .ramReq, .ramWrite, .ramAddr, .ramWData);

  mainRam i_mainRam (.clk, .rst, .ramReq, .ramWrite, .ramAddr, .ramWData,
                     .ramAck, .ramRData);

endmodule

// ==== bench/memSubsys_sva.sv ====
// memSubsysSva: four-phase handshake and grant checks bound into the bus arbiter
module memSubsysSva import memPkg::*; (
  input logic clk,
  input logic rst,
  input logic cReq,
  input logic cAck,
  input logic ldReq,
  input logic ldAck,
  input logic ramReq,
  input logic ramAck,
  input logic granted,
  input logic owner
);

  // number of failed assertions so far
  int errCount = 0;

  //////////////////////////////////////////////////
  // arbiter grant
  //////////////////////////////////////////////////

  // grant and owner stay put through a four-phase cycle
  grantHeld: assert property (@(posedge clk) disable iff (rst)
      granted && (ramReq || ramAck) |=> granted && $stable(owner))
    else begin
      errCount++;
      $error("grant changed before the owner finished");
    end

  // RAM only answers a granted request
  ackInGrant: assert property (@(posedge clk) disable iff (rst) ramAck |-> granted)
    else begin
      errCount++;
      $error("RAM ack seen with no grant");
    end

  //////////////////////////////////////////////////
  // four-phase rules
  //////////////////////////////////////////////////

  // RAM raises ack only while a request is up
  ackForReq: assert property (@(posedge clk) disable iff (rst) $rose(ramAck) |-> ramReq)
    else begin
      errCount++;
      $error("RAM raised ack with no request pending");
    end

  // requesters hold req until ack arrives
  cacheReqHeld: assert property (@(posedge clk) disable iff (rst) cReq && !cAck |=> cReq)
    else begin
      errCount++;
      $error("cache dropped its request before ack");
    end

  loaderReqHeld: assert property (@(posedge clk) disable iff (rst) ldReq && !ldAck |=> ldReq)
    else begin
      errCount++;
      $error("loader dropped its request before ack");
    end

  // RAM keeps ack up while req is still high
  ramAckHeld: assert property (@(posedge clk) disable iff (rst) ramAck && ramReq |=> ramAck)
    else begin
      errCount++;
      $error("RAM dropped ack while the request was still high");
    end

endmodule

bind busArbiter memSubsysSva i_sva (.*);

// ==== bench/memSubsysTb.sv ====
// memSubsysTb: testbench running file commands through the host, loader and flush ports
module memSubsysTb import memPkg::*; ();

  logic              clk;
  logic              rst;
  logic              hostReq;
  logic              hostWrite;
  logic [ADDR_W-1:0] hostAddr;
  logic [DATA_W-1:0] hostWData;
  logic              hostAck;
  logic [DATA_W-1:0] hostRData;
  logic              ldReq;
  logic              ldWrite;
  logic [ADDR_W-1:0] ldAddr;
  logic [DATA_W-1:0] ldWData;
  logic              ldAck;
  logic [DATA_W-1:0] ldRData;
  logic              flushReq;
  logic              flushAck;

  // one command per entry with op, address, data and expected read value
  logic [79:0]       cmdMem [64];
  logic [7:0]        cmdOp;
  logic [ADDR_W-1:0] cmdAddr;
  logic [DATA_W-1:0] cmdData;
  logic [DATA_W-1:0] cmdExp;
  int                cmdIdx;
  logic              done;

  // memory model of RAM contents plus a mirror of the cache lines
  logic [DATA_W-1:0] ramModel [RAM_WORDS];
  logic [TAG_W-1:0]  mTag [NUM_LINES];
  logic [DATA_W-1:0] mData [NUM_LINES];
  lineState_t        mState [NUM_LINES];

  logic [DATA_W-1:0] expHost;
  logic [DATA_W-1:0] expLd;
  logic [DATA_W-1:0] gotHost;
  logic [DATA_W-1:0] gotLd;
  logic [15:0]       lfsrState;
  int                hostDelay;
  int                ldDelay;
  int                timeoutCycles = 400;

  memSubsys i_dut (.clk, .rst, .hostReq, .hostWrite, .hostAddr, .hostWData, .hostAck,
                   .hostRData, .ldReq, .ldWrite, .ldAddr, .ldWData, .ldAck, .ldRData,
                   .flushReq, .flushAck);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reporting and compare
  //////////////////////////////////////////////////
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic compareRead(input string who, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR at time %0t: %s read of %02h gave %08h, expected %08h",
                        $time, who, a, got, exp));
    end
  endtask

  task automatic expectAck(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // the file's expected column must agree with the model
  task automatic confirmStimulus(input logic [DATA_W-1:0] modelVal);
    if (modelVal !== cmdExp) begin
      failRun($sformatf("stimulus entry %0d expects %08h but the memory model gives %08h",
                        cmdIdx, cmdExp, modelVal));
    end
  endtask

  // a bound assertion that fires ends the run at the next edge
  always @(posedge clk) begin
    if (i_dut.i_busArbiter.i_sva.errCount != 0) begin
      failRun("a handshake assertion in the bus arbiter failed");
    end
  end

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////
  task automatic updateOnHostWrite(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    logic [LINE_W-1:0] idx;
    idx = a[LINE_W-1:0];
    // dirty victim with another tag goes back to RAM
    if (mState[idx] == dirty && mTag[idx] != a[ADDR_W-1:LINE_W]) begin
      ramModel[{mTag[idx], idx}] = mData[idx];
    end
    mTag[idx]   = a[ADDR_W-1:LINE_W];
    mData[idx]  = d;
    mState[idx] = dirty;
  endtask

  task automatic predictHostRead(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] v);
    logic [LINE_W-1:0] idx;
    idx = a[LINE_W-1:0];
    if (mState[idx] == invalid || mTag[idx] != a[ADDR_W-1:LINE_W]) begin
      if (mState[idx] == dirty) begin
        ramModel[{mTag[idx], idx}] = mData[idx];
      end
      // refill from RAM
      mTag[idx]   = a[ADDR_W-1:LINE_W];
      mData[idx]  = ramModel[a];
      mState[idx] = clean;
    end
    v = mData[idx];
  endtask

  task automatic applyFlushToModel();
    for (int i = 0; i < NUM_LINES; i++) begin
      if (mState[i] == dirty) begin
        ramModel[{mTag[i], i[LINE_W-1:0]}] = mData[i];
        mState[i] = clean;
      end
    end
  endtask

  // 16-bit Galois LFSR stepped once per bit taken
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic randomBits(input int nBits, output int val);
    val = 0;
    for (int b = 0; b < nBits; b++) begin
      lfsrState = lfsrStep(lfsrState);
      val = (val << 1) | lfsrState[0];
    end
  endtask

  //////////////////////////////////////////////////
  // port handshakes
  //////////////////////////////////////////////////
  task automatic hostAccess(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rd);
    int t;
    @(posedge clk);
    hostReq   <= 1'b1;
    hostWrite <= wr;
    hostAddr  <= a;
    hostWData <= d;
    t = 0;
    while (hostAck !== 1'b1) begin
      @(posedge clk);
      t++;
      if (t > timeoutCycles) begin
        failRun("host request got no hostAck before the timeout");
      end
    end
    // read data valid while ack is high
    rd = hostRData;
    hostReq <= 1'b0;
    t = 0;
    while (hostAck !== 1'b0) begin
      @(posedge clk);
      t++;
      if (t > timeoutCycles) begin
        failRun("hostAck did not drop after hostReq fell");
      end
    end
  endtask

  task automatic loaderAccess(input logic wr, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rd);
    int t;
    @(posedge clk);
    ldReq   <= 1'b1;
    ldWrite <= wr;
    ldAddr  <= a;
    ldWData <= d;
    t = 0;
    while (ldAck !== 1'b1) begin
      @(posedge clk);
      t++;
      if (t > timeoutCycles) begin
        failRun("loader request got no ldAck before the timeout");
      end
    end
    rd = ldRData;
    ldReq <= 1'b0;
    t = 0;
    while (ldAck !== 1'b0) begin
      @(posedge clk);
      t++;
      if (t > timeoutCycles) begin
        failRun("ldAck did not drop after ldReq fell");
      end
    end
  endtask

  task automatic runFlush();
    int t;
    @(posedge clk);
    flushReq <= 1'b1;
    t = 0;
    while (flushAck !== 1'b1) begin
      @(posedge clk);
      t++;
      if (t > timeoutCycles) begin
        failRun("flush was never acknowledged on flushAck");
      end
    end
    flushReq <= 1'b0;
    t = 0;
    while (flushAck !== 1'b0) begin
      @(posedge clk);
      t++;
      if (t > timeoutCycles) begin
        failRun("flushAck did not drop after flushReq fell");
      end
    end
    // no second ack once the flush is complete
    @(posedge clk);
    expectAck("flushAck", flushAck, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // command sequence
  //////////////////////////////////////////////////
  initial begin
    rst       = 1'b1;
    hostReq   = 1'b0;
    hostWrite = 1'b0;
    hostAddr  = '0;
    hostWData = '0;
    ldReq     = 1'b0;
    ldWrite   = 1'b0;
    ldAddr    = '0;
    ldWData   = '0;
    flushReq  = 1'b0;
    lfsrState = 16'd59913;
    for (int i = 0; i < NUM_LINES; i++) begin
      mState[i] = invalid;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ramModel[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      cmdMem[i] = '0;
    end
    $readmemh("bench/memStimulus.txt", cmdMem);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // no ack without a request
    repeat (5) begin
      @(posedge clk);
      expectAck("hostAck", hostAck, 1'b0);
      expectAck("ldAck", ldAck, 1'b0);
      expectAck("flushAck", flushAck, 1'b0);
    end
    cmdIdx = 0;
    done   = 1'b0;
    while (!done) begin
      {cmdOp, cmdAddr, cmdData, cmdExp} = cmdMem[cmdIdx];
      case (cmdOp)
        8'h00: done = 1'b1;
        8'h01: begin
          updateOnHostWrite(cmdAddr, cmdData);
          hostAccess(1'b1, cmdAddr, cmdData, gotHost);
        end
        8'h02: begin
          predictHostRead(cmdAddr, expHost);
          confirmStimulus(expHost);
          hostAccess(1'b0, cmdAddr, '0, gotHost);
          compareRead("host", cmdAddr, gotHost, cmdExp);
        end
        8'h03: begin
          ramModel[cmdAddr] = cmdData;
          loaderAccess(1'b1, cmdAddr, cmdData, gotLd);
        end
        8'h04: begin
          confirmStimulus(ramModel[cmdAddr]);
          loaderAccess(1'b0, cmdAddr, '0, gotLd);
          compareRead("loader", cmdAddr, gotLd, cmdExp);
        end
        8'h05: begin
          applyFlushToModel();
          runFlush();
        end
        8'h06: begin
          // host read and loader read contend for the RAM
          predictHostRead(cmdAddr, expHost);
          confirmStimulus(expHost);
          expLd = ramModel[cmdData[ADDR_W-1:0]];
          randomBits(2, hostDelay);
          randomBits(2, ldDelay);
          fork
            begin
              repeat (hostDelay) @(posedge clk);
              hostAccess(1'b0, cmdAddr, '0, gotHost);
            end
            begin
              repeat (ldDelay) @(posedge clk);
              loaderAccess(1'b0, cmdData[ADDR_W-1:0], '0, gotLd);
            end
          join
          compareRead("host", cmdAddr, gotHost, cmdExp);
          compareRead("loader", cmdData[ADDR_W-1:0], gotLd, expLd);
        end
        default: failRun($sformatf("stimulus entry %0d has unknown op %02h", cmdIdx, cmdOp));
      endcase
      cmdIdx++;
      if (cmdIdx == 64) begin
        done = 1'b1;
      end
    end
    repeat (2) @(posedge clk);
    if (i_dut.i_busArbiter.i_sva.errCount != 0) begin
      failRun("handshake assertions failed during the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== bench/memStimulus.txt ====
// columns op_addr_data_expect, all hex; op 01 host write, 02 host read, 03 loader write,
// 04 loader read, 05 flush, 06 host read of addr with loader read of data[7:0], 00 end
// preload through the loader
03_10_A5A50010_00000000
03_11_A5A50011_00000000
03_22_A5A50022_00000000
03_33_A5A50033_00000000
03_44_A5A50044_00000000
03_55_A5A50055_00000000
03_18_A5A50018_00000000
03_1D_A5A5001D_00000000
03_2C_A5A5002C_00000000
// host reads refill from RAM
02_10_00000000_A5A50010
02_11_00000000_A5A50011
02_10_00000000_A5A50010
02_22_00000000_A5A50022
// host writes, hits and dirty evictions on index 0
01_10_C0DE0010_00000000
02_10_00000000_C0DE0010
01_18_C0DE0018_00000000
02_18_00000000_C0DE0018
02_10_00000000_C0DE0010
04_10_00000000_C0DE0010
04_18_00000000_C0DE0018
01_33_C0DE0033_00000000
02_33_00000000_C0DE0033
// dirty lines stay hidden from the loader until a flush
04_33_00000000_A5A50033
01_11_C0DE0011_00000000
04_11_00000000_A5A50011
05_00_00000000_00000000
04_33_00000000_C0DE0033
04_11_00000000_C0DE0011
02_11_00000000_C0DE0011
// host and loader contend for the RAM
06_44_00000055_A5A50044
06_2C_00000010_A5A5002C
01_55_C0DE0055_00000000
01_4C_C0DE004C_00000000
06_1D_00000022_A5A5001D
04_55_00000000_C0DE0055
06_4C_00000033_C0DE004C
05_00_00000000_00000000
04_4C_00000000_C0DE004C
06_22_0000004C_A5A50022
02_18_00000000_C0DE0018
04_2C_00000000_A5A5002C
06_18_00000011_C0DE0018
// end of commands
00_00_00000000_00000000

// ==== list.f ====
rtl/memPkg.sv
rtl/mainRam.sv
rtl/busArbiter.sv
rtl/dataCache.sv
rtl/cacheFlush.sv
rtl/memSubsys.sv
bench/memSubsys_sva.sv
bench/memSubsysTb.sv
